//--- sources.f
hw/mips_mem_pkg.sv
hw/data_ram.sv
hw/ram_arbiter.sv
hw/mem_stage.sv
hw/debug_mem_reader.sv
hw/mem_subsystem_top.sv
dv/mem_subsystem_tb.sv

//--- dv/mem_stimulus.txt
# group kind step addr wdata mem_bus wb_bus reg zero halt expected pc_src (numbers in hex)
# expected is the stored word on S lines and read_data on L lines, ignored elsewhere
store_load S 1 00000000 11111111 001 1 01 0 0 11111111 0
store_load S 1 00000004 22222222 001 2 02 0 0 22222222 0
store_load L 1 00000000 00000000 002 3 03 0 0 11111111 0
store_load L 1 00000004 00000000 002 1 04 0 0 22222222 0
store_load S 1 00000108 33333333 001 2 05 0 0 33333333 0
store_load L 1 00000008 00000000 002 3 06 0 0 33333333 0
subword S 1 0000000c 12348765 041 1 07 0 0 ffff8765 0
subword S 1 00000010 abcd0042 081 2 08 0 0 00000042 0
subword L 1 0000000c 00000000 002 3 09 0 0 ffff8765 0
subword L 1 00000010 00000000 002 0 0a 0 0 00000042 0
extend S 1 00000014 00008000 001 1 0b 0 0 00008000 0
extend S 1 00000018 00000080 001 2 0c 0 0 00000080 0
extend L 1 00000014 00000000 012 3 0d 0 0 ffff8000 0
extend L 1 00000014 00000000 01a 1 0e 0 0 00008000 0
extend L 1 00000018 00000000 022 2 0f 0 0 ffffff80 0
extend L 1 00000018 00000000 02a 3 10 0 0 00000080 0
branch B 1 00000100 00000000 000 0 11 0 0 00000000 0
branch B 1 00000104 00000000 000 1 12 1 0 00000000 0
branch B 1 00000108 00000000 004 2 13 0 0 00000000 0
branch B 1 0000010c 00000000 004 3 14 1 0 00000000 1
branch B 1 00000110 00000000 104 0 15 0 0 00000000 1
branch B 1 00000114 00000000 104 1 16 1 0 00000000 0
branch B 1 00000118 00000000 100 2 17 0 0 00000000 0
branch B 1 0000011c 00000000 100 3 18 1 0 00000000 0
hold_pipe P 1 00000020 00000000 000 3 1f 0 1 00000000 0
hold_pipe S 1 0000001c 77777777 001 2 19 0 0 77777777 0
hold_pipe L 1 0000001c 00000000 002 1 1a 0 1 77777777 0
hold_pipe S 0 0000001c deadbeef 001 2 1b 0 0 deadbeef 0
hold_pipe L 1 0000001c 00000000 002 0 1c 0 0 77777777 0
dump D 0 00000000 00000000 000 0 00 0 0 00000000 0

//--- dv/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb
	import mips_mem_pkg::*;
();

	localparam int RAM_DEPTH = 64;
	localparam int DUMP_WORDS = 8;
	localparam int CLK_PERIOD = 40;
	localparam int MAX_LINES = 64;

	logic clk, reset, step_en, zero_flag, halt_in, dump_start;
	logic [WORD_W-1:0] addr_in, write_data, pc_branch_in;
	logic [MEM_BUS_W-1:0] mem_bus;
	logic [WB_BUS_W-1:0] wb_bus_in;
	logic [REG_ADDR_W-1:0] write_reg_in;
	logic [WORD_W-1:0] read_data, pc_branch, addr_out, dbg_word;
	logic pc_src, halt_out, dbg_valid, dump_done;
	logic [WB_BUS_W-1:0] wb_bus_out;
	logic [REG_ADDR_W-1:0] write_reg_out;
	logic [$clog2(RAM_DEPTH)-1:0] dbg_word_addr;

	// One entry per stimulus line
	logic [8*16-1:0] grp_v [MAX_LINES];
	logic [7:0] kind_v [MAX_LINES];
	logic step_v [MAX_LINES], zero_v [MAX_LINES], halt_v [MAX_LINES], pcs_v [MAX_LINES];
	logic [WORD_W-1:0] addr_v [MAX_LINES], wdata_v [MAX_LINES], exp_v [MAX_LINES];
	logic [MEM_BUS_W-1:0] bus_v [MAX_LINES];
	logic [WB_BUS_W-1:0] wb_v [MAX_LINES];
	logic [REG_ADDR_W-1:0] reg_v [MAX_LINES];

	// Reference memory and the expected MEM/WB registers
	logic [WORD_W-1:0] model [RAM_DEPTH];
	logic [WORD_W-1:0] exp_rd, exp_addr;
	logic [WB_BUS_W-1:0] exp_wb;
	logic [REG_ADDR_W-1:0] exp_reg;
	logic exp_halt, rd_known;

	logic [8*16-1:0] cur_group;
	int num_lines, checks, errors, group_start, tests_passed, tests_failed;
	int cycle_count, cycle_limit;

	mem_subsystem_top #(.RAM_DEPTH(RAM_DEPTH), .DUMP_WORDS(DUMP_WORDS)) dut (
		.clk(clk), .reset(reset), .step_en(step_en), .addr_in(addr_in),
		.write_data(write_data), .mem_bus(mem_bus), .wb_bus_in(wb_bus_in),
		.write_reg_in(write_reg_in), .zero_flag(zero_flag), .pc_branch_in(pc_branch_in),
		.halt_in(halt_in), .dump_start(dump_start), .read_data(read_data),
		.pc_src(pc_src), .pc_branch(pc_branch), .wb_bus_out(wb_bus_out),
		.addr_out(addr_out), .write_reg_out(write_reg_out), .halt_out(halt_out),
		.dbg_word(dbg_word), .dbg_word_addr(dbg_word_addr), .dbg_valid(dbg_valid),
		.dump_done(dump_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("ERROR at %0d ns: %0s expected %h got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic close_group();
		if (cur_group != '0)
		begin
			if (errors == group_start)
				tests_passed++;
			else
				tests_failed++;
			$display("Test %0s: %0s", cur_group, (errors == group_start) ? "ok" : "failed");
		end
	endtask

	// Byte address to RAM word, wrapping at the RAM size
	function automatic int word_index(input logic [31:0] byte_addr);
		return (byte_addr >> 2) % RAM_DEPTH;
	endfunction

	function automatic logic [31:0] extend_load(input logic [31:0] word,
		input logic [MEM_BUS_W-1:0] bus);
		if (bus[MB_LOAD_HALF])
			return bus[MB_UNSIGNED] ? {16'h0, word[15:0]} : {{16{word[15]}}, word[15:0]};
		if (bus[MB_LOAD_BYTE])
			return bus[MB_UNSIGNED] ? {24'h0, word[7:0]} : {{24{word[7]}}, word[7:0]};
		return word;
	endfunction

	// Dump with random stage reads stealing the RAM port
	task automatic run_dump();
		int count;
		bit done;
		count = 0;
		done = 0;
		step_en = 1'b0;
		mem_bus = '0;
		dump_start = 1'b1;
		@(negedge clk);
		dump_start = 1'b0;
		while (!done)
		begin
			step_en = ($urandom % 4 == 0);
			mem_bus = step_en ? 9'h002 : 9'h000;
			addr_in = ($urandom % DUMP_WORDS) << 2;
			@(negedge clk);
			if (dbg_valid)
			begin
				check_value("dbg_word_addr", count, dbg_word_addr);
				check_value("dbg_word", model[count], dbg_word);
				count++;
			end
			if (dump_done)
			begin
				check_value("dumped word count", DUMP_WORDS, count);
				done = 1;
			end
		end
		step_en = 1'b0;
		mem_bus = '0;
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial
	begin
		int fd, n, seed;
		logic [8*16-1:0] tok;
		logic [8*200-1:0] rest;
		seed = $urandom(99);
		cycle_limit = 1000;
		{reset, step_en, zero_flag, halt_in, dump_start} = 5'b10000;
		{addr_in, write_data, pc_branch_in} = '0;
		{mem_bus, wb_bus_in, write_reg_in} = '0;
		{exp_rd, exp_addr, exp_wb, exp_reg, exp_halt} = '0;
		rd_known = 1'b1;
		fd = $fopen("dv/mem_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open dv/mem_stimulus.txt");
			$display("FAIL: see errors above");
			$finish;
		end
		while ($fscanf(fd, "%s", tok) == 1)
		begin
			if (tok == "#")
				n = $fgets(rest, fd);
			else
			begin
				n = $fscanf(fd, " %s %h %h %h %h %h %h %h %h %h %h", kind_v[num_lines],
					step_v[num_lines], addr_v[num_lines], wdata_v[num_lines],
					bus_v[num_lines], wb_v[num_lines], reg_v[num_lines], zero_v[num_lines],
					halt_v[num_lines], exp_v[num_lines], pcs_v[num_lines]);
				if (n != 11)
				begin
					$display("Stimulus line %0d is malformed", num_lines + 1);
					errors++;
				end
				grp_v[num_lines] = tok;
				num_lines++;
			end
		end
		$fclose(fd);
		cycle_limit = 20 * num_lines + 4 * DUMP_WORDS + 50;

		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("dbg_valid", 0, dbg_valid);
		check_value("dump_done", 0, dump_done);
		check_value("read_data", 0, read_data);
		check_value("wb_bus_out", 0, wb_bus_out);
		check_value("addr_out", 0, addr_out);
		check_value("write_reg_out", 0, write_reg_out);
		check_value("halt_out", 0, halt_out);

		for (int i = 0; i < num_lines; i++)
		begin
			if (grp_v[i] != cur_group)
			begin
				close_group();
				cur_group = grp_v[i];
				group_start = errors;
			end
			if (kind_v[i] == "D")
				run_dump();
			else
			begin
				step_en = step_v[i];
				addr_in = addr_v[i];
				write_data = wdata_v[i];
				mem_bus = bus_v[i];
				wb_bus_in = wb_v[i];
				write_reg_in = reg_v[i];
				zero_flag = zero_v[i];
				halt_in = halt_v[i];
				pc_branch_in = addr_v[i] + 32'h0040_0000;
				#(CLK_PERIOD / 4);
				check_value("pc_src", pcs_v[i], pc_src);
				check_value("pc_branch", pc_branch_in, pc_branch);
				if (step_v[i])
				begin
					exp_wb = wb_v[i];
					exp_addr = addr_v[i];
					exp_reg = reg_v[i];
					exp_halt = halt_v[i];
					rd_known = (kind_v[i] == "L");
					exp_rd = exp_v[i];
					if (kind_v[i] == "S")
						model[word_index(addr_v[i])] = exp_v[i];
					if (kind_v[i] == "L")
						check_value("model load", exp_v[i],
							extend_load(model[word_index(addr_v[i])], bus_v[i]));
				end
				@(negedge clk);
				if (rd_known)
					check_value("read_data", exp_rd, read_data);
				check_value("wb_bus_out", exp_wb, wb_bus_out);
				check_value("addr_out", exp_addr, addr_out);
				check_value("write_reg_out", exp_reg, write_reg_out);
				check_value("halt_out", exp_halt, halt_out);
			end
		end
		close_group();

		$display("Tests passed %0d, failed %0d, %0d checks with %0d errors",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- hw/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top
	import mips_mem_pkg::*;
#(
	parameter int RAM_DEPTH = 2048,
	parameter int DUMP_WORDS = 16
)(
	input logic clk,
	input logic reset,
	input logic step_en,
	input logic [WORD_W-1:0] addr_in,
	input logic [WORD_W-1:0] write_data,
	input logic [MEM_BUS_W-1:0] mem_bus,
	input logic [WB_BUS_W-1:0] wb_bus_in,
	input logic [REG_ADDR_W-1:0] write_reg_in,
	input logic zero_flag,
	input logic [WORD_W-1:0] pc_branch_in,
	input logic halt_in,
	input logic dump_start,
	output logic [WORD_W-1:0] read_data,
	output logic pc_src,
	output logic [WORD_W-1:0] pc_branch,
	output logic [WB_BUS_W-1:0] wb_bus_out,
	output logic [WORD_W-1:0] addr_out,
	output logic [REG_ADDR_W-1:0] write_reg_out,
	output logic halt_out,
	output logic [WORD_W-1:0] dbg_word,
	output logic [$clog2(RAM_DEPTH)-1:0] dbg_word_addr,
	output logic dbg_valid,
	output logic dump_done
);

	localparam int IDX_W = $clog2(RAM_DEPTH);

	// Stage side
	logic [WORD_W-1:0] stage_addr;
	logic [WORD_W-1:0] stage_wdata;
	logic stage_we;
	logic stage_re;

	// Debug side
	logic dbg_req;
	logic dbg_gnt;
	logic [IDX_W-1:0] dbg_addr;

	// RAM port
	logic [IDX_W-1:0] ram_addr;
	logic [WORD_W-1:0] ram_wdata;
	logic ram_we;
	logic [WORD_W-1:0] ram_rdata;

	mem_stage u_mem_stage (
		.clk(clk), .reset(reset), .step_en(step_en),
		.addr_in(addr_in), .write_data(write_data), .mem_bus(mem_bus),
		.wb_bus_in(wb_bus_in), .write_reg_in(write_reg_in), .zero_flag(zero_flag),
		.pc_branch_in(pc_branch_in), .halt_in(halt_in), .ram_rdata(ram_rdata),
		.stage_addr(stage_addr), .stage_wdata(stage_wdata),
		.stage_we(stage_we), .stage_re(stage_re),
		.read_data(read_data), .pc_src(pc_src), .pc_branch(pc_branch),
		.wb_bus_out(wb_bus_out), .addr_out(addr_out),
		.write_reg_out(write_reg_out), .halt_out(halt_out)
	);

	debug_mem_reader #(.RAM_DEPTH(RAM_DEPTH), .DUMP_WORDS(DUMP_WORDS)) u_debug_mem_reader (
		.clk(clk), .reset(reset), .dump_start(dump_start),
		.dbg_gnt(dbg_gnt), .ram_rdata(ram_rdata),
		.dbg_req(dbg_req), .dbg_addr(dbg_addr), .dbg_word(dbg_word),
		.dbg_word_addr(dbg_word_addr), .dbg_valid(dbg_valid), .dump_done(dump_done)
	);

	ram_arbiter #(.RAM_DEPTH(RAM_DEPTH)) u_ram_arbiter (
		.clk(clk), .reset(reset),
		.stage_addr(stage_addr), .stage_wdata(stage_wdata),
		.stage_we(stage_we), .stage_re(stage_re),
		.dbg_req(dbg_req), .dbg_addr(dbg_addr), .dbg_gnt(dbg_gnt),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we)
	);

	data_ram #(.RAM_DEPTH(RAM_DEPTH)) u_data_ram (
		.clk(clk), .addr(ram_addr), .wdata(ram_wdata),
		.we(ram_we), .rdata(ram_rdata)
	);

endmodule

//--- hw/debug_mem_reader.sv
`timescale 1ns/1ps

module debug_mem_reader
	import mips_mem_pkg::*;
#(
	parameter int RAM_DEPTH = 2048,
	parameter int DUMP_WORDS = 16
)(
	input logic clk,
	input logic reset,
	input logic dump_start,
	input logic dbg_gnt,
	input logic [WORD_W-1:0] ram_rdata,
	output logic dbg_req,
	output logic [$clog2(RAM_DEPTH)-1:0] dbg_addr,
	output logic [WORD_W-1:0] dbg_word,
	output logic [$clog2(RAM_DEPTH)-1:0] dbg_word_addr,
	output logic dbg_valid,
	output logic dump_done
);

	localparam int IDX_W = $clog2(RAM_DEPTH);
	localparam logic [IDX_W-1:0] LAST_ADDR = IDX_W'(DUMP_WORDS - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_DONE
	} state_t;

	state_t state;

	assign dbg_req = (state == ST_READ);

	////////////////////////////////////////
	// Control FSM and address counter
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			dbg_addr <= '0;
			dbg_valid <= 1'b0;
			dump_done <= 1'b0;
		end
		else
		begin
			dbg_valid <= 1'b0;
			dump_done <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (dump_start)
					begin
						dbg_addr <= '0;
						state <= ST_READ;
					end
				end
				ST_READ:
				begin
					// Hold the address until the stage lets go of the RAM
					if (dbg_gnt)
					begin
						dbg_valid <= 1'b1;
						if (dbg_addr == LAST_ADDR)
						begin
							state <= ST_DONE;
						end
						else
						begin
							dbg_addr <= dbg_addr + 1'b1;
						end
					end
				end
				default:
				begin
					dump_done <= 1'b1;
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Captured word and its index
	always_ff @(posedge clk)
	begin
		if (dbg_req && dbg_gnt)
		begin
			dbg_word <= ram_rdata;
			dbg_word_addr <= dbg_addr;
		end
	end

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
	import mips_mem_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic step_en,
	input logic [WORD_W-1:0] addr_in,
	input logic [WORD_W-1:0] write_data,
	input logic [MEM_BUS_W-1:0] mem_bus,
	input logic [WB_BUS_W-1:0] wb_bus_in,
	input logic [REG_ADDR_W-1:0] write_reg_in,
	input logic zero_flag,
	input logic [WORD_W-1:0] pc_branch_in,
	input logic halt_in,
	input logic [WORD_W-1:0] ram_rdata,
	output logic [WORD_W-1:0] stage_addr,
	output logic [WORD_W-1:0] stage_wdata,
	output logic stage_we,
	output logic stage_re,
	output logic [WORD_W-1:0] read_data,
	output logic pc_src,
	output logic [WORD_W-1:0] pc_branch,
	output logic [WB_BUS_W-1:0] wb_bus_out,
	output logic [WORD_W-1:0] addr_out,
	output logic [REG_ADDR_W-1:0] write_reg_out,
	output logic halt_out
);

	logic mem_write;
	logic mem_read;
	logic branch;
	logic is_unsigned;
	logic load_half;
	logic load_byte;
	logic store_half;
	logic store_byte;
	logic branch_ne;

	logic [WORD_W-1:0] load_word;

	////////////////////////////////////////
	// Control bus decode
	////////////////////////////////////////

	assign mem_write = mem_bus[MB_MEM_WRITE];
	assign mem_read = mem_bus[MB_MEM_READ];
	assign branch = mem_bus[MB_BRANCH];
	assign is_unsigned = mem_bus[MB_UNSIGNED];
	assign load_half = mem_bus[MB_LOAD_HALF];
	assign load_byte = mem_bus[MB_LOAD_BYTE];
	assign store_half = mem_bus[MB_STORE_HALF];
	assign store_byte = mem_bus[MB_STORE_BYTE];
	assign branch_ne = mem_bus[MB_BRANCH_NE];

	////////////////////////////////////////
	// Branch resolution
	////////////////////////////////////////

	// beq takes on zero, bne on non-zero
	assign pc_src = branch & (branch_ne ? ~zero_flag : zero_flag);
	assign pc_branch = pc_branch_in;

	////////////////////////////////////////
	// Memory request
	////////////////////////////////////////

	assign stage_addr = addr_in;

	// Stores only land on a pipeline step
	assign stage_we = mem_write & step_en;
	assign stage_re = mem_read;

	// Sub-word stores write the whole word, sign-extended
	always_comb
	begin
		if (store_half)
		begin
			stage_wdata = {{16{write_data[15]}}, write_data[15:0]};
		end
		else if (store_byte)
		begin
			stage_wdata = {{24{write_data[7]}}, write_data[7:0]};
		end
		else
		begin
			stage_wdata = write_data;
		end
	end

	////////////////////////////////////////
	// Load extension
	////////////////////////////////////////

	always_comb
	begin
		if (load_half)
		begin
			if (is_unsigned)
			begin
				load_word = {16'd0, ram_rdata[15:0]};
			end
			else
			begin
				load_word = {{16{ram_rdata[15]}}, ram_rdata[15:0]};
			end
		end
		else if (load_byte)
		begin
			if (is_unsigned)
			begin
				load_word = {24'd0, ram_rdata[7:0]};
			end
			else
			begin
				load_word = {{24{ram_rdata[7]}}, ram_rdata[7:0]};
			end
		end
		else
		begin
			load_word = ram_rdata;
		end
	end

	////////////////////////////////////////
	// MEM/WB registers
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			read_data <= '0;
			wb_bus_out <= '0;
			addr_out <= '0;
			write_reg_out <= '0;
			halt_out <= 1'b0;
		end
		else if (step_en)
		begin
			read_data <= load_word;
			wb_bus_out <= wb_bus_in;
			addr_out <= addr_in;
			write_reg_out <= write_reg_in;
			halt_out <= halt_in;
		end
	end

endmodule

//--- hw/ram_arbiter.sv
`timescale 1ns/1ps

module ram_arbiter
	import mips_mem_pkg::*;
#(
	parameter int RAM_DEPTH = 2048
)(
	input logic clk,
	input logic reset,
	input logic [WORD_W-1:0] stage_addr,
	input logic [WORD_W-1:0] stage_wdata,
	input logic stage_we,
	input logic stage_re,
	input logic dbg_req,
	input logic [$clog2(RAM_DEPTH)-1:0] dbg_addr,
	output logic dbg_gnt,
	output logic [$clog2(RAM_DEPTH)-1:0] ram_addr,
	output logic [WORD_W-1:0] ram_wdata,
	output logic ram_we
);

	localparam int IDX_W = $clog2(RAM_DEPTH);

	logic [WORD_W-1:0] stage_word;
	logic [IDX_W-1:0] stage_idx;
	logic stage_busy;

	// Byte address to word index, wrapping at RAM_DEPTH
	assign stage_word = stage_addr >> 2;
	assign stage_idx = IDX_W'(stage_word % WORD_W'(RAM_DEPTH));

	// Stage always wins
	assign stage_busy = stage_we | stage_re;
	assign dbg_gnt = dbg_req & ~stage_busy;

	assign ram_addr = dbg_gnt ? dbg_addr : stage_idx;
	assign ram_wdata = stage_wdata;

	// A stage write never shares a cycle with a debug grant
	assign ram_we = stage_we;

endmodule

//--- hw/data_ram.sv
`timescale 1ns/1ps

module data_ram
	import mips_mem_pkg::*;
#(
	parameter int RAM_DEPTH = 2048
)(
	input logic clk,
	input logic [$clog2(RAM_DEPTH)-1:0] addr,
	input logic [WORD_W-1:0] wdata,
	input logic we,
	output logic [WORD_W-1:0] rdata
);

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	logic [WORD_W-1:0] mem [RAM_DEPTH];

	// Read is asynchronous, so a load sees
	// the word in the same cycle
	assign rdata = mem[addr];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[addr] <= wdata;
		end
	end

endmodule

//--- hw/mips_mem_pkg.sv
package mips_mem_pkg;

	////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////

	// Data word and byte address
	localparam int WORD_W = 32;

	// Register file index
	localparam int REG_ADDR_W = 5;

	// Control buses carried down the pipeline
	localparam int MEM_BUS_W = 9;
	localparam int WB_BUS_W = 2;

	////////////////////////////////////////
	// Memory control bus bit positions
	////////////////////////////////////////

	// Basic access strobes
	localparam int MB_MEM_WRITE = 0;
	localparam int MB_MEM_READ = 1;

	// Taken for both beq and bne, see MB_BRANCH_NE
	localparam int MB_BRANCH = 2;

	// Zero extension for lhu / lbu
	localparam int MB_UNSIGNED = 3;

	// Sub-word loads
	localparam int MB_LOAD_HALF = 4;
	localparam int MB_LOAD_BYTE = 5;

	// Sub-word stores, still written as a full word
	localparam int MB_STORE_HALF = 6;
	localparam int MB_STORE_BYTE = 7;

	// Selects bne over beq
	localparam int MB_BRANCH_NE = 8;

endpackage
